/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= taggedMemTb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir

SIM      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := Done: no errors

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST) src/mem_defs.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only when the pass line appears in the simulator output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* files.f */
+incdir+src
src/memPkg.sv
src/laneBus.sv
src/reqFront.sv
src/byteLane.sv
src/respMerge.sv
src/taggedMem.sv
verif/taggedMem_checker.sv
verif/taggedMemTb.sv

/* src/byteLane.sv */
// byteLane: one 9-bit single-ported read-first RAM lane with read enable
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module byteLane #(
    parameter int LANE = 0
) (
    input  logic clk,
    laneBus.lane bus
);

    localparam int Depth = 1 << `MEM_ADDR_WIDTH;

    logic [`MEM_LANE_WIDTH-1:0] mem [Depth];
    logic [`MEM_LANE_WIDTH-1:0] readQ;

    // read and write share the accept edge, the old entry is captured first
    always_ff @(posedge clk) begin
        if (bus.accept) begin
            readQ <= mem[bus.addr];
            if (bus.writeEn[LANE]) begin
                mem[bus.addr] <= {bus.writeTag, bus.writeByte[LANE]};
            end
        end
    end

    // readQ holds while accept is low, which keeps a stalled response stable
    assign bus.readByte[LANE] = readQ[`MEM_BYTE_WIDTH-1:0];
    assign bus.readTag[LANE]  = readQ[`MEM_LANE_WIDTH-1];

endmodule

`default_nettype wire

/* src/laneBus.sv */
// laneBus interface: lane commands from the front, read results to the merger
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

interface laneBus
    import memPkg::*;
();

    // command side, driven by the request front
    logic                        accept;
    memAddr                      addr;
    logic [`MEM_LANES-1:0]       writeEn;
    logic [`MEM_BYTE_WIDTH-1:0]  writeByte [`MEM_LANES];
    logic                        writeTag;

    // each lane drives only its own element
    wire  [`MEM_BYTE_WIDTH-1:0]  readByte [`MEM_LANES];
    wire  [`MEM_LANES-1:0]       readTag;

    // from the merger, high when a new request may enter
    logic                        slotFree;

    modport front (
        output accept,
        output addr,
        output writeEn,
        output writeByte,
        output writeTag,
        input  slotFree
    );

    modport lane (
        input  accept,
        input  addr,
        input  writeEn,
        input  writeByte,
        input  writeTag,
        output readByte,
        output readTag
    );

    modport merger (
        input  accept,
        input  readByte,
        input  readTag,
        output slotFree
    );

    // observation only
    modport top (
        input  accept,
        input  addr,
        input  writeEn,
        input  writeByte,
        input  writeTag,
        input  readByte,
        input  readTag,
        input  slotFree
    );

endinterface

`default_nettype wire

/* src/memPkg.sv */
// memPkg: opcode enum and the word, mask and address types of the tagged memory
`default_nettype none

`include "mem_defs.svh"

package memPkg;

    // request opcodes
    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } memOp;

    // full data word, lane i holds bits [8i+7:8i]
    typedef logic [`MEM_LANES*`MEM_BYTE_WIDTH-1:0] memWord;

    // one select bit per byte lane
    typedef logic [`MEM_LANES-1:0] memMask;

    // word address
    typedef logic [`MEM_ADDR_WIDTH-1:0] memAddr;

endpackage

`default_nettype wire

/* src/mem_defs.svh */
// sizes of the tagged word memory: address width, byte lanes, lane and byte widths
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// 64 words
`define MEM_ADDR_WIDTH 6

// byte lanes per word
`define MEM_LANES 4

// stored lane is one data byte plus the grubby tag bit
`define MEM_LANE_WIDTH 9

// data bits of one lane
`define MEM_BYTE_WIDTH (`MEM_LANE_WIDTH - 1)

`endif

/* src/reqFront.sv */
// reqFront: request handshake, opcode decode, lane write enables and stored tag bit
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module reqFront
    import memPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   reqValid,
    output logic   reqReady,
    input  memOp   reqOp,
    input  memAddr reqAddr,
    input  memMask reqMask,
    input  memWord reqData,
    input  logic   reqTag,
    laneBus.front  bus
);

    logic   isWrite;
    logic   partial;
    memAddr addrHold;

    // ready follows the merger, a request goes in when both sides agree
    assign reqReady   = bus.slotFree;
    assign bus.accept = reqValid & bus.slotFree;

    always_comb begin
        case (reqOp)
            opRead:  isWrite = 1'b0;
            opWrite: isWrite = 1'b1;
            default: isWrite = 1'b0;
        endcase
    end

    // reads and refused requests leave every lane untouched
    assign bus.writeEn = (bus.accept && isWrite) ? reqMask : '0;

    // a partial write marks the word grubby
    assign partial      = (reqMask != '1);
    assign bus.writeTag = partial | reqTag;

    always_comb begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            bus.writeByte[i] = reqData[i*`MEM_BYTE_WIDTH +: `MEM_BYTE_WIDTH];
        end
    end

    // keep the last accepted address on the lane bus while idle
    // so the RAM address lines do not follow every idle request
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            addrHold <= '0;
        end else if (bus.accept) begin
            addrHold <= reqAddr;
        end
    end

    assign bus.addr = bus.accept ? reqAddr : addrHold;

endmodule

`default_nettype wire

/* src/respMerge.sv */
// respMerge: pending response flag, slot-free flow control, word and tag assembly
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module respMerge
    import memPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    output logic   respValid,
    input  logic   respReady,
    output memWord respData,
    output logic   respTag,
    laneBus.merger bus
);

    logic pending;
    logic taken;

    assign respValid = pending;
    assign taken     = pending & respReady;

    // one response slot, it frees up in the same cycle the response leaves
    assign bus.slotFree = !pending || respReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending <= 1'b0;
        end else if (bus.accept) begin
            // a new request refills the slot even if the old response left
            pending <= 1'b1;
        end else if (taken) begin
            pending <= 1'b0;
        end
    end

    always_comb begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            respData[i*`MEM_BYTE_WIDTH +: `MEM_BYTE_WIDTH] = bus.readByte[i];
        end
    end

    // word is grubby when any lane is
    assign respTag = |bus.readTag;

endmodule

`default_nettype wire

/* src/taggedMem.sv */
// taggedMem: top level with request front, generated byte lanes and response merger
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module taggedMem
    import memPkg::*;
(
    input  logic   clk,
    input  logic   rstN,

    // request
    input  logic   reqValid,
    output logic   reqReady,
    input  memOp   reqOp,
    input  memAddr reqAddr,
    input  memMask reqMask,
    input  memWord reqData,
    input  logic   reqTag,

    // response
    output logic   respValid,
    input  logic   respReady,
    output memWord respData,
    output logic   respTag
);

    laneBus bus ();

    reqFront front (
        .clk      (clk),
        .rstN     (rstN),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .reqOp    (reqOp),
        .reqAddr  (reqAddr),
        .reqMask  (reqMask),
        .reqData  (reqData),
        .reqTag   (reqTag),
        .bus      (bus)
    );

    for (genvar i = 0; i < `MEM_LANES; i++) begin : gLane
        byteLane #(
            .LANE (i)
        ) lane (
            .clk (clk),
            .bus (bus)
        );
    end

    respMerge merge (
        .clk       (clk),
        .rstN      (rstN),
        .respValid (respValid),
        .respReady (respReady),
        .respData  (respData),
        .respTag   (respTag),
        .bus       (bus)
    );

endmodule

`default_nettype wire

/* verif/taggedMemTb.sv */
// taggedMemTb: random-stimulus testbench with reference model, compare task and watchdog
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module taggedMemTb
    import memPkg::*;
();

    localparam int Words       = 1 << `MEM_ADDR_WIDTH;
    localparam int Lanes       = `MEM_LANES;
    localparam int ByteW       = 8;
    localparam int RandomCount = 300;
    localparam int TotalReqs   = 3 * Words + RandomCount;
    localparam int LimitCycles = TotalReqs * 4 + 200;

    localparam int KindFill   = 0;
    localparam int KindRead   = 1;
    localparam int KindRandom = 2;

    logic   clk;
    logic   rstN;
    logic   reqValid;
    logic   reqReady;
    memOp   reqOp;
    memAddr reqAddr;
    memMask reqMask;
    memWord reqData;
    logic   reqTag;
    logic   respValid;
    logic   respReady;
    memWord respData;
    logic   respTag;

    // reference model, one byte and one tag bit per lane
    logic [ByteW-1:0] modelByte  [Words][Lanes];
    logic             modelTag   [Words][Lanes];
    bit               modelKnown [Words];

    // expected responses in request order
    memWord expData  [$];
    logic   expTag   [$];
    bit     expKnown [$];
    int     expCycle [$];

    logic [31:0] rngState;
    int          cycle;
    int          errorCount;
    bit          fullSpeed;

    taggedMem dut (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .reqOp     (reqOp),
        .reqAddr   (reqAddr),
        .reqMask   (reqMask),
        .reqData   (reqData),
        .reqTag    (reqTag),
        .respValid (respValid),
        .respReady (respReady),
        .respData  (respData),
        .respTag   (respTag)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // sample both handshakes at a rising edge and keep the model in step
    task automatic observeEdge();
        memWord word;
        logic   tag;
        logic   wrTag;
        int     a;
        cycle++;
        if (respValid && respReady) begin
            if (expData.size() == 0) begin
                $display("response returned with no request outstanding");
                $display("Done: errors found");
                $fatal(1, "unexpected response");
            end else begin
                word = expData.pop_front();
                tag  = expTag.pop_front();
                if (expKnown.pop_front()) begin
                    compare("response data", word, respData);
                    compare("response tag", 32'(tag), 32'(respTag));
                end
                if (fullSpeed) begin
                    compare("response latency", 32'(expCycle.pop_front() + 1), 32'(cycle));
                end else begin
                    void'(expCycle.pop_front());
                end
            end
        end
        if (fullSpeed && reqValid) begin
            compare("reqReady at full speed", 32'd1, 32'(reqReady));
        end
        if (reqValid && reqReady) begin
            a    = int'(reqAddr);
            word = '0;
            tag  = 1'b0;
            for (int i = 0; i < Lanes; i++) begin
                word[i*ByteW +: ByteW] = modelByte[a][i];
                tag = tag | modelTag[a][i];
            end
            expData.push_back(word);
            expTag.push_back(tag);
            expKnown.push_back(modelKnown[a]);
            expCycle.push_back(cycle);
            // old word is captured above before the write lands
            if (reqOp == opWrite) begin
                wrTag = ~&reqMask || reqTag;
                for (int i = 0; i < Lanes; i++) begin
                    if (reqMask[i]) begin
                        modelByte[a][i] = reqData[i*ByteW +: ByteW];
                        modelTag[a][i]  = wrTag;
                    end
                end
                if (&reqMask) begin
                    modelKnown[a] = 1'b1;
                end
            end
        end
    endtask

    task automatic driveRequest(input int kind, input int index);
        logic [31:0] r;
        r = nextRandom();
        reqValid <= 1'b1;
        case (kind)
            KindFill: begin
                reqOp   <= opWrite;
                reqAddr <= memAddr'(index);
                reqMask <= '1;
                reqData <= nextRandom();
                reqTag  <= r[0];
            end
            KindRead: begin
                reqOp   <= opRead;
                reqAddr <= memAddr'(index);
                reqMask <= memMask'(r[3:0]);
                reqData <= nextRandom();
                reqTag  <= r[4];
            end
            default: begin
                reqOp   <= memOp'(r[0]);
                reqAddr <= memAddr'(r[6:1]);
                // roughly one in eight requests has an empty mask
                reqMask <= (r[9:7] == 3'b000) ? '0 : memMask'(r[13:10]);
                reqData <= nextRandom();
                reqTag  <= r[14];
            end
        endcase
    endtask

    task automatic runPhase(input int kind, input int count);
        int issued;
        bit active;
        issued = 0;
        active = 1'b0;
        while (issued < count || active) begin
            @(posedge clk);
            observeEdge();
            if (active && reqReady) begin
                active = 1'b0;
            end
            if (kind == KindRandom) begin
                // back-pressure about 30% of cycles
                respReady <= (nextRandom() % 10) >= 3;
            end else begin
                respReady <= 1'b1;
            end
            if (!active) begin
                if (issued < count && !(kind == KindRandom && nextRandom() % 5 == 0)) begin
                    driveRequest(kind, issued);
                    issued++;
                    active = 1'b1;
                end else begin
                    reqValid <= 1'b0;
                end
            end
        end
    endtask

    task automatic drainResponses();
        respReady <= 1'b1;
        reqValid  <= 1'b0;
        while (expData.size() != 0) begin
            @(posedge clk);
            observeEdge();
        end
    endtask

    initial begin
        rngState   = 32'he02b;
        cycle      = 0;
        errorCount = 0;
        fullSpeed  = 1'b0;
        rstN       = 1'b0;
        reqValid   = 1'b0;
        reqOp      = opRead;
        reqAddr    = '0;
        reqMask    = '0;
        reqData    = '0;
        reqTag     = 1'b0;
        respReady  = 1'b0;
        for (int w = 0; w < Words; w++) begin
            modelKnown[w] = 1'b0;
        end
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        fullSpeed = 1'b1;
        runPhase(KindFill, Words);
        drainResponses();
        runPhase(KindRead, Words);
        drainResponses();
        fullSpeed = 1'b0;
        runPhase(KindRandom, RandomCount);
        drainResponses();
        fullSpeed = 1'b1;
        runPhase(KindRead, Words);
        drainResponses();
        // one idle edge, a repeated last response would still be pending here
        @(posedge clk);
        compare("respValid after drain", 32'd0, 32'(respValid));
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // limit scales with the number of requests
    initial begin
        repeat (LimitCycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", LimitCycles);
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* verif/taggedMem_checker.sv */
// taggedMemChecker: bound assertions on the handshakes and the reset state, plus its bind
`default_nettype none
`timescale 1ns/1ps

module taggedMemChecker
    import memPkg::*;
(
    input logic   clk,
    input logic   rstN,
    input logic   reqReady,
    input logic   respValid,
    input logic   respReady,
    input memWord respData,
    input logic   respTag
);

    // no response is pending while reset is held
    resetIdle: assert property (@(posedge clk) !rstN |-> !respValid)
        else $error("respValid high during reset");

    // a stalled response keeps its value until it is taken
    stallHold: assert property (@(posedge clk) disable iff (!rstN)
        respValid && !respReady |=> respValid && $stable(respData) && $stable(respTag))
        else $error("response changed while stalled");

    readyIdle: assert property (@(posedge clk) disable iff (!rstN)
        !respValid |-> reqReady)
        else $error("reqReady low with no response pending");

endmodule

bind taggedMem taggedMemChecker handshakeCheck (
    .clk       (clk),
    .rstN      (rstN),
    .reqReady  (reqReady),
    .respValid (respValid),
    .respReady (respReady),
    .respData  (respData),
    .respTag   (respTag)
);

`default_nettype wire
